// ==== src/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int num_ways = 2;
    localparam int way_w    = 1;
    localparam int num_sets = 16;
    localparam int index_w  = 4;
    localparam int tag_w    = 12;
    localparam int addr_w   = 16;
    localparam int data_w   = 32;

    typedef struct packed {
        logic [tag_w-1:0]   tag;   // upper bits.
        logic [index_w-1:0] index; // selects the set.
    } cache_addr_fields_t;

    // read as a raw word address or as tag and index.
    typedef union packed {
        logic [addr_w-1:0]  word;
        cache_addr_fields_t fields;
    } cache_addr_u;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        cache_addr_u adr;
    } up_req_t;

    typedef struct packed {
        logic              ack;
        logic              rty;
        logic [data_w-1:0] dat;
    } up_resp_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [addr_w-1:0] adr;
    } down_req_t;

    typedef struct packed {
        logic              ack;
        logic              rty;
        logic [data_w-1:0] dat;
    } down_resp_t;

    typedef struct packed {
        logic [way_w-1:0] way_sel;
        logic             src_sel;  // 1 selects downstream fill data.
        logic             load;
        logic             load_lru;
    } cache_ctrl_t;

endpackage : cache_pkg

`default_nettype wire

// ==== src/lru_array.sv ====
`default_nettype none

module lru_array (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [cache_pkg::index_w-1:0] index,
    input  cache_pkg::cache_ctrl_t       ctrl,
    output logic [cache_pkg::way_w-1:0]  lru_way
);
    import cache_pkg::*;

    // per set, the way to evict next.
    logic [num_sets-1:0][way_w-1:0] lru_q;

    assign lru_way = lru_q[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q <= '0;
        end else if (ctrl.load_lru) begin
            lru_q[index] <= ~ctrl.way_sel; // the way that did not hit.
        end
    end

endmodule : lru_array

`default_nettype wire

// ==== src/cache_datapath.sv ====
`default_nettype none

module cache_datapath (
    input  logic                           clk,
    input  logic                           rst,
    input  cache_pkg::cache_addr_u         addr,
    input  cache_pkg::cache_ctrl_t         ctrl,
    input  logic [cache_pkg::data_w-1:0]   fill_dat,
    output logic [cache_pkg::num_ways-1:0] hit,
    output logic [cache_pkg::data_w-1:0]   rd_dat
);
    import cache_pkg::*;

    logic [tag_w-1:0]  tag_mem  [num_ways][num_sets];
    logic [data_w-1:0] data_mem [num_ways][num_sets];

    // one valid bit per way and set.
    logic [num_ways-1:0][num_sets-1:0] valid_q;

    logic [index_w-1:0] index;
    logic [tag_w-1:0]   tag;
    logic [data_w-1:0]  line_dat;

    assign index = addr.fields.index;
    assign tag   = addr.fields.tag;

    // both ways compared in parallel.
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit[w] = valid_q[w][index] && (tag_mem[w][index] == tag);
        end
    end

    assign rd_dat = data_mem[ctrl.way_sel][index];

    // the upstream side carries no write data and keeps the stored word.
    assign line_dat = ctrl.src_sel ? fill_dat : rd_dat;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (ctrl.load) begin
            valid_q[ctrl.way_sel][index] <= 1'b1;
        end
    end

    // tag and data follow the valid bit.
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            tag_mem[ctrl.way_sel][index]  <= tag;
            data_mem[ctrl.way_sel][index] <= line_dat;
        end
    end

endmodule : cache_datapath

`default_nettype wire

// ==== src/readonly_cache_controller.sv ====
`default_nettype none

module readonly_cache_controller (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cache_pkg::num_ways-1:0] hit,
    input  logic [cache_pkg::way_w-1:0]   lru_way,
    input  logic                          up_cyc,
    input  logic                          up_stb,
    input  logic                          down_ack,
    input  logic                          down_rty,
    output cache_pkg::cache_ctrl_t        ctrl,
    output logic                          up_ack,
    output logic                          up_rty,
    output logic                          down_cyc,
    output logic                          down_stb,
    output logic                          down_we,
    output logic                          debug_hit,
    output logic                          debug_miss
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        st_idle_hit,
        st_fetch,
        st_fetch_release
    } state_t;

    state_t state;
    state_t next_state;
    logic   req;
    logic   any_hit;

    assign req     = up_cyc & up_stb;
    assign any_hit = |hit;
    assign down_we = 1'b0; // never writes memory.

    always_comb begin
        ctrl       = '0;
        up_ack     = 1'b0;
        up_rty     = 1'b1;  // retry unless a hit is answered.
        down_cyc   = 1'b0;
        down_stb   = 1'b0;
        debug_hit  = 1'b0;
        debug_miss = 1'b0;

        case (state)
            st_idle_hit: begin
                for (int i = 0; i < num_ways; i++) begin
                    if (hit[i]) begin
                        ctrl.way_sel = way_w'(i);
                    end
                end
                if (req) begin
                    if (any_hit) begin
                        debug_hit     = 1'b1;
                        ctrl.load_lru = 1'b1;
                        up_ack        = 1'b1;
                        up_rty        = 1'b0;
                    end else begin
                        debug_miss = 1'b1;
                        down_cyc   = 1'b1; // ask for the bus without a strobe.
                    end
                end
            end

            st_fetch: begin
                ctrl.way_sel = lru_way; // fill the victim.
                ctrl.src_sel = 1'b1;
                ctrl.load    = 1'b1;    // last write lands in the ack cycle.
                down_cyc     = 1'b1;
                down_stb     = 1'b1;
            end

            st_fetch_release: begin
                down_cyc = 1'b1; // hold the bus until ack drops.
            end

            default: begin
            end
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle_hit: begin
                if (req && !any_hit && !down_rty) begin
                    next_state = st_fetch;
                end
            end
            st_fetch: begin
                if (down_ack) next_state = st_fetch_release;
            end
            st_fetch_release: begin
                if (!down_ack) next_state = st_idle_hit;
            end
            default: next_state = st_idle_hit;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle_hit;
        end else begin
            state <= next_state;
        end
    end

endmodule : readonly_cache_controller

`default_nettype wire

// ==== src/readonly_cache.sv ====
`default_nettype none

module readonly_cache (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::up_req_t    up_req,
    input  cache_pkg::down_resp_t down_resp,
    output cache_pkg::up_resp_t   up_resp,
    output cache_pkg::down_req_t  down_req,
    output logic                  debug_hit,
    output logic                  debug_miss
);
    import cache_pkg::*;

    cache_ctrl_t         ctrl;
    logic [num_ways-1:0] hit;
    logic [way_w-1:0]    lru_way;
    logic [data_w-1:0]   rd_dat;
    logic                up_ack;
    logic                up_rty;
    logic                down_cyc;
    logic                down_stb;
    logic                down_we;

    readonly_cache_controller u_controller (
        .clk        (clk),
        .rst        (rst),
        .hit        (hit),
        .lru_way    (lru_way),
        .up_cyc     (up_req.cyc),
        .up_stb     (up_req.stb),
        .down_ack   (down_resp.ack),
        .down_rty   (down_resp.rty),
        .ctrl       (ctrl),
        .up_ack     (up_ack),
        .up_rty     (up_rty),
        .down_cyc   (down_cyc),
        .down_stb   (down_stb),
        .down_we    (down_we),
        .debug_hit  (debug_hit),
        .debug_miss (debug_miss)
    );

    cache_datapath u_datapath (
        .clk      (clk),
        .rst      (rst),
        .addr     (up_req.adr),
        .ctrl     (ctrl),
        .fill_dat (down_resp.dat),
        .hit      (hit),
        .rd_dat   (rd_dat)
    );

    lru_array u_lru (
        .clk     (clk),
        .rst     (rst),
        .index   (up_req.adr.fields.index),
        .ctrl    (ctrl),
        .lru_way (lru_way)
    );

    assign up_resp = '{ack: up_ack, rty: up_rty, dat: rd_dat};

    // miss fetches use the request address as is.
    assign down_req = '{cyc: down_cyc, stb: down_stb, we: down_we, adr: up_req.adr.word};

endmodule : readonly_cache

`default_nettype wire

// ==== test/backing_memory_model.sv ====
`default_nettype none

module backing_memory_model (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::down_req_t  req,
    input  logic [1:0]            rty_delay,
    input  logic [1:0]            ack_delay,
    output cache_pkg::down_resp_t resp
);
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    logic [1:0] rty_cnt; // cycles of retry left once cyc rises.
    logic [1:0] ack_cnt; // cycles of strobe before ack.
    logic       ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rty_cnt <= '0;
            ack_cnt <= '0;
            ack_q   <= 1'b0;
        end else begin
            if (!req.cyc) begin
                rty_cnt <= rty_delay;
            end else if (!req.stb && rty_cnt != 0) begin
                rty_cnt <= rty_cnt - 2'd1;
            end

            if (!req.stb) begin
                ack_cnt <= ack_delay;
                ack_q   <= 1'b0;
            end else if (ack_cnt != 0) begin
                ack_cnt <= ack_cnt - 2'd1;
            end else begin
                ack_q <= 1'b1; // held while stb stays high.
            end
        end
    end

    // word at address a is a followed by its inverse.
    assign resp = '{ack: ack_q,
                    rty: req.cyc ? (rty_cnt != 0) : 1'b1,
                    dat: {req.adr, ~req.adr}};

endmodule : backing_memory_model

`default_nettype wire

// ==== test/tb_readonly_cache.sv ====
`default_nettype none

module tb_readonly_cache;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    localparam int num_random  = 200;
    localparam int num_tests   = 5;
    localparam int cycle_limit = (num_random + 6) * 12 + 50;
    localparam int t_reset = 0;
    localparam int t_lru   = 1;
    localparam int t_read  = 2;
    localparam int t_hit   = 3;
    localparam int t_down  = 4;

    logic       clk;
    logic       rst;
    up_req_t    up_req;
    up_resp_t   up_resp;
    down_req_t  down_req;
    down_resp_t down_resp;
    logic       debug_hit;
    logic       debug_miss;
    logic [1:0] rty_delay;
    logic [1:0] ack_delay;

    logic [15:0] lfsr_state = 16'd46298;
    int          test_errors [num_tests];
    string       test_names [num_tests] = '{"reset_idle", "lru_eviction", "read_data",
                                            "hit_or_miss", "read_only_downstream"};
    int          checks = 0;
    int          cycle_count = 0;
    int          down_ack_count = 0;
    int          model_misses = 0;

    logic [11:0] model_tag [2][16]; // reference cache state.
    logic        model_valid [2][16];
    logic        model_lru [16];

    readonly_cache u_readonly_cache (
        .clk        (clk),
        .rst        (rst),
        .up_req     (up_req),
        .down_resp  (down_resp),
        .up_resp    (up_resp),
        .down_req   (down_req),
        .debug_hit  (debug_hit),
        .debug_miss (debug_miss)
    );

    backing_memory_model u_backing_memory (
        .clk       (clk),
        .rst       (rst),
        .req       (down_req),
        .rty_delay (rty_delay),
        .ack_delay (ack_delay),
        .resp      (down_resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fetch count, write enable and the run limit.
    always @(posedge clk) begin
        cycle_count++;
        if (down_req.cyc && down_req.stb && down_resp.ack) down_ack_count++;
        assert (!down_req.we) else begin
            test_errors[t_down]++;
            $display("downstream write enable went high in cycle %0d", cycle_count);
        end
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // 16-bit galois lfsr stepped once per bit.
    function automatic logic [3:0] next_random_bits(input int n);
        logic [3:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r[k] = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0);
        end
        return r;
    endfunction

    task automatic compare_value(input int id, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            test_errors[id]++;
            $display("FAIL %s %s: expected %h, actual %h", test_names[id], what,
                     expected, actual);
        end
    endtask

    function automatic logic model_lookup(input logic [15:0] addr, output logic way);
        logic found;
        found = 1'b0;
        way   = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][addr[3:0]] && model_tag[w][addr[3:0]] == addr[15:4]) begin
                found = 1'b1;
                way   = w[0];
            end
        end
        return found;
    endfunction

    // a miss fills the lru way and the retried request hits there.
    function automatic void model_update(input logic [15:0] addr, input logic was_hit,
                                         input logic way);
        logic use_way;
        use_way = way;
        if (!was_hit) begin
            use_way = model_lru[addr[3:0]];
            model_valid[use_way][addr[3:0]] = 1'b1;
            model_tag[use_way][addr[3:0]]   = addr[15:4];
            model_misses++;
        end
        model_lru[addr[3:0]] = ~use_way;
    endfunction

    task automatic run_request(input logic [15:0] addr, input int id, output logic was_miss);
        logic exp_hit;
        logic way;
        logic first;
        logic done;
        logic seen_miss;
        int   acks_before;
        exp_hit     = model_lookup(addr, way);
        acks_before = down_ack_count;
        first       = 1'b1;
        done        = 1'b0;
        seen_miss   = 1'b0;
        @(negedge clk);
        up_req.cyc      = 1'b1;
        up_req.stb      = 1'b1;
        up_req.adr.word = addr;
        while (!done) begin
            #1; // outputs settle well before the rising edge.
            if (first) begin
                seen_miss = debug_miss;
                compare_value(id, "debug_hit", exp_hit, debug_hit);
                compare_value(id, "debug_miss", !exp_hit, debug_miss);
                if (exp_hit) compare_value(id, "same-cycle ack", 1, up_resp.ack);
            end
            first = 1'b0;
            if (up_resp.ack) begin
                compare_value(t_read, "data", {addr, ~addr}, up_resp.dat);
                if (!exp_hit) begin
                    assert (down_ack_count > acks_before) else begin
                        test_errors[id]++;
                        $display("miss on %h was acknowledged before memory answered", addr);
                    end
                end
                done = 1'b1;
            end
            @(posedge clk);
            if (!done) @(negedge clk);
        end
        @(negedge clk);
        up_req.cyc = 1'b0;
        up_req.stb = 1'b0;
        rty_delay  = next_random_bits(2); // delays for the next fetch.
        ack_delay  = next_random_bits(2);
        model_update(addr, exp_hit, way);
        was_miss = seen_miss;
    endtask

    task automatic report_test(input int id);
        if (test_errors[id] == 0) $display("test %-22s ok", test_names[id]);
        else $display("test %-22s %0d errors", test_names[id], test_errors[id]);
    endtask

    initial begin
        logic [15:0] lru_seq [6];
        logic [5:0]  pattern;
        logic [3:0]  r;
        logic        miss;
        int          total;
        lru_seq   = '{16'h0117, 16'h0227, 16'h0117,
                      16'h0337, 16'h0227, 16'h0117};
        up_req    = '0;
        rty_delay = 2'd0;
        ack_delay = 2'd0;
        rst       = 1'b1;
        foreach (test_errors[i]) test_errors[i] = 0;
        foreach (model_lru[s]) model_lru[s] = 1'b0;
        foreach (model_valid[w, s]) model_valid[w][s] = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        #1;
        compare_value(t_reset, "up ack", 0, up_resp.ack);
        compare_value(t_reset, "up rty", 1, up_resp.rty);
        compare_value(t_reset, "down cyc", 0, down_req.cyc);
        compare_value(t_reset, "down stb", 0, down_req.stb);
        compare_value(t_reset, "down we", 0, down_req.we);
        report_test(t_reset);

        // a, b, a, c, b, a in set 7 gives miss miss hit miss miss miss.
        for (int k = 0; k < 6; k++) begin
            run_request(lru_seq[k], t_lru, miss);
            pattern[k] = miss;
        end
        compare_value(t_lru, "miss pattern", 6'b111011, pattern);
        report_test(t_lru);

        // four tags over sets 0 to 3 keep evictions frequent.
        for (int n = 0; n < num_random; n++) begin
            r = next_random_bits(4);
            run_request({8'h5a, 2'b00, r[3:2], 2'b00, r[1:0]}, t_hit, miss);
        end
        report_test(t_read);
        report_test(t_hit);

        repeat (4) @(negedge clk);
        compare_value(t_down, "fetch count", model_misses, down_ack_count);
        report_test(t_down);

        total = 0;
        foreach (test_errors[i]) total += test_errors[i];
        $display("%0d tests, %0d checks, %0d errors", num_tests, checks, total);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_readonly_cache

`default_nettype wire

// ==== readonly_cache.f ====
src/cache_pkg.sv
src/lru_array.sv
src/cache_datapath.sv
src/readonly_cache_controller.sv
src/readonly_cache.sv
test/backing_memory_model.sv
test/tb_readonly_cache.sv

// ==== Bender.yml ====
package:
  name: readonly_cache

sources:
  - files:
      - src/cache_pkg.sv
      - src/lru_array.sv
      - src/cache_datapath.sv
      - src/readonly_cache_controller.sv
      - src/readonly_cache.sv

  - target: test
    files:
      - test/backing_memory_model.sv
      - test/tb_readonly_cache.sv
